// File: verilog.f
common/flag_cfg_pkg.sv
common/flag_types_pkg.sv
common/flag_write_if.sv
src/flag_init_sweep.sv
src/flag_write_stage.sv
bank/flag_bank.sv
src/flag_read_bypass.sv
src/flag_regfile.sv
dv/flag_regfile_tb.sv

// File: Makefile
TOP = flag_regfile_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module flag_regfile

sim:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/flag_regfile_tb.sv
// Table-driven testbench of the flag register file with a reference model
`timescale 1ns/1ps

module flag_regfile_tb;

  typedef enum logic [2:0] {OP_IDLE, OP_WRITE, OP_ALLOC, OP_READ, OP_RETIRE} op_e;

  // A joined row shares its cycle with the row after it
  typedef struct packed {
    op_e op;
    logic port;
    flag_types_pkg::reg_addr_t addr;
    flag_types_pkg::flag_t data;
    logic joined;
    logic has_exp;
    flag_types_pkg::entry_t exp;
  } row_t;

  logic clk;
  logic rst;
  logic read_en;
  flag_types_pkg::reg_addr_t read_addr;
  logic retire_en;
  flag_types_pkg::reg_addr_t retire_addr;
  logic wr0_en;
  flag_types_pkg::reg_addr_t wr0_addr;
  flag_types_pkg::flag_t wr0_data;
  logic wr1_en;
  flag_types_pkg::reg_addr_t wr1_addr;
  flag_types_pkg::flag_t wr1_data;
  logic alloc_en;
  flag_types_pkg::reg_addr_t alloc_addr;
  flag_types_pkg::entry_t read_data;
  flag_types_pkg::flag_t retire_data;
  logic init_busy;

  row_t rows [$];
  flag_types_pkg::entry_t model [flag_cfg_pkg::ENTRY_COUNT];
  flag_types_pkg::entry_t exp_read;   // Value read_data must show now
  flag_types_pkg::flag_t exp_retire;
  integer seed;

  flag_regfile i_flag_regfile (
    .clk         (clk),
    .rst         (rst),
    .read_en     (read_en),
    .read_addr   (read_addr),
    .retire_en   (retire_en),
    .retire_addr (retire_addr),
    .wr0_en      (wr0_en),
    .wr0_addr    (wr0_addr),
    .wr0_data    (wr0_data),
    .wr1_en      (wr1_en),
    .wr1_addr    (wr1_addr),
    .wr1_data    (wr1_data),
    .alloc_en    (alloc_en),
    .alloc_addr  (alloc_addr),
    .read_data   (read_data),
    .retire_data (retire_data),
    .init_busy   (init_busy)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_entry(string name, flag_types_pkg::entry_t act,
                             flag_types_pkg::entry_t exp);
    if (act !== exp)
    begin
      $display("Fail at %0t: %s is %h, expected %h", $time, name, act, exp);
      $display("TB FAILED");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic check_flags(string name, flag_types_pkg::flag_t act,
                             flag_types_pkg::flag_t exp);
    if (act !== exp)
    begin
      $display("Fail at %0t: %s is %h, expected %h", $time, name, act, exp);
      $display("TB FAILED");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic check_busy(string name, logic act, logic exp);
    if (act !== exp)
    begin
      $display("Fail at %0t: %s is %b, expected %b", $time, name, act, exp);
      $display("TB FAILED");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic report_timeout(string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("TB FAILED");
    $fatal(1, "Stopped on timeout");
  endtask

  task automatic add_row(op_e op, logic port, int addr, int data, logic joined,
                         logic has_exp, int exp);
    row_t r;
    r.op = op;
    r.port = port;
    r.addr = addr[flag_cfg_pkg::ADDR_WIDTH-1:0];
    r.data = data[flag_cfg_pkg::FLAG_WIDTH-1:0];
    r.joined = joined;
    r.has_exp = has_exp;
    r.exp = exp[flag_cfg_pkg::FLAG_WIDTH:0];
    rows.push_back(r);
  endtask

  task automatic build_table();
    op_e op;
    for (int a = 0; a < flag_cfg_pkg::ENTRY_COUNT; a++)
      add_row(OP_READ, 0, a, 0, 0, 1, 0);   // All clear after the sweep
    add_row(OP_WRITE, 0, 5, 'h2a, 0, 0, 0);
    add_row(OP_IDLE, 0, 0, 0, 0, 0, 0);
    add_row(OP_READ, 0, 5, 0, 0, 1, 'h2a);
    add_row(OP_RETIRE, 0, 5, 0, 0, 1, 'h2a);
    add_row(OP_ALLOC, 0, 9, 0, 0, 0, 0);
    add_row(OP_READ, 0, 9, 0, 0, 1, 'h7f);
    add_row(OP_RETIRE, 0, 9, 0, 0, 1, 'h3f);
    add_row(OP_WRITE, 1, 9, 'h11, 0, 0, 0);
    add_row(OP_READ, 0, 9, 0, 0, 1, 'h11);
    // Same cycle write, retire and read of one entry
    add_row(OP_WRITE, 0, 12, 'h15, 1, 0, 0);
    add_row(OP_RETIRE, 0, 12, 0, 1, 1, 'h00);
    add_row(OP_READ, 0, 12, 0, 0, 1, 'h15);
    add_row(OP_READ, 0, 12, 0, 0, 1, 'h15);
    add_row(OP_WRITE, 0, 20, 'h01, 1, 0, 0);
    add_row(OP_WRITE, 1, 20, 'h02, 1, 0, 0);
    add_row(OP_ALLOC, 0, 20, 0, 1, 0, 0);
    add_row(OP_READ, 0, 20, 0, 0, 1, 'h7f);   // forwarded
    add_row(OP_READ, 0, 20, 0, 0, 1, 'h7f);
    add_row(OP_WRITE, 0, 21, 'h03, 1, 0, 0);
    add_row(OP_WRITE, 1, 21, 'h04, 1, 0, 0);
    add_row(OP_READ, 0, 21, 0, 0, 1, 'h04);
    add_row(OP_READ, 0, 21, 0, 0, 1, 'h04);
    add_row(OP_WRITE, 0, 30, 'h33, 1, 0, 0);   // read_data must hold 04
    add_row(OP_WRITE, 1, 21, 'h0c, 0, 0, 0);
    for (int i = 0; i < 80; i++)
    begin
      op = op_e'($unsigned($random(seed)) % 5);
      add_row(op, 1'($random(seed)), $random(seed), $random(seed),
              ($random(seed) & 3) == 0, 0, 0);
    end
    add_row(OP_IDLE, 0, 0, 0, 0, 0, 0);
    add_row(OP_IDLE, 0, 0, 0, 0, 0, 0);
  endtask

  // Drives one cycle of rows and moves the model and expectations along
  task automatic apply_cycle(inout int idx);
    row_t r;
    logic use_rd_exp;
    logic use_ret_exp;
    flag_types_pkg::entry_t rd_exp;
    flag_types_pkg::entry_t ret_exp;
    wr0_en = 1'b0;
    wr1_en = 1'b0;
    alloc_en = 1'b0;
    read_en = 1'b0;
    retire_en = 1'b0;
    use_rd_exp = 1'b0;
    use_ret_exp = 1'b0;
    do
    begin
      r = rows[idx];
      idx++;
      case (r.op)
        OP_WRITE:
        begin
          if (r.port)
          begin
            wr1_en = 1'b1;
            wr1_addr = r.addr;
            wr1_data = r.data;
          end
          else
          begin
            wr0_en = 1'b1;
            wr0_addr = r.addr;
            wr0_data = r.data;
          end
        end
        OP_ALLOC:
        begin
          alloc_en = 1'b1;
          alloc_addr = r.addr;
        end
        OP_READ:
        begin
          read_en = 1'b1;
          read_addr = r.addr;
          use_rd_exp = r.has_exp;
          rd_exp = r.exp;
        end
        OP_RETIRE:
        begin
          retire_en = 1'b1;
          retire_addr = r.addr;
          use_ret_exp = r.has_exp;
          ret_exp = r.exp;
        end
        default:
        begin
        end
      endcase
    end while (r.joined && idx < rows.size());
    // Retire sees storage before this cycle's writes
    if (retire_en)
      exp_retire = use_ret_exp ? ret_exp[flag_cfg_pkg::FLAG_WIDTH-1:0]
                               : model[retire_addr][flag_cfg_pkg::FLAG_WIDTH-1:0];
    if (wr0_en)
      model[wr0_addr] = {1'b0, wr0_data};
    if (wr1_en)
      model[wr1_addr] = {1'b0, wr1_data};   // port 1 over port 0
    if (alloc_en)
      model[alloc_addr] = '1;
    if (read_en)
      exp_read = use_rd_exp ? rd_exp : model[read_addr];
  endtask

  initial
  begin
    int idx;
    int wait_cnt;
    seed = 32'hd5881b70;
    rst = 1'b1;
    read_en = 1'b0;
    read_addr = '0;
    retire_en = 1'b0;
    retire_addr = '0;
    // Payload of the requests offered during the sweep
    wr0_en = 1'b0;
    wr0_addr = 6'd7;
    wr0_data = 6'h2d;
    wr1_en = 1'b0;
    wr1_addr = 6'd44;
    wr1_data = 6'h1b;
    alloc_en = 1'b0;
    alloc_addr = 6'd58;
    exp_read = '0;
    exp_retire = '0;
    foreach (model[i])
      model[i] = '0;
    build_table();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    wait_cnt = 0;
    while (init_busy !== 1'b0 && wait_cnt < 200)
    begin
      wr0_en = 1'b1;   // Ignored while busy
      wr1_en = 1'b1;
      alloc_en = 1'b1;
      @(negedge clk);
      wait_cnt++;
      check_entry("read_data", read_data, '0);
      check_flags("retire_data", retire_data, '0);
      // Sweep writes, the stage cycle, then one more
      check_busy("init_busy", init_busy, wait_cnt < flag_cfg_pkg::ENTRY_COUNT + 2);
    end
    if (init_busy !== 1'b0)
      report_timeout("init_busy still high 200 cycles after reset");
    idx = 0;
    while (idx < rows.size())
    begin
      apply_cycle(idx);
      @(negedge clk);
      check_entry("read_data", read_data, exp_read);
      check_flags("retire_data", retire_data, exp_retire);
      check_busy("init_busy", init_busy, 1'b0);
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

// File: src/flag_regfile.sv
// Top level of the banked condition flag register file
`timescale 1ns/1ps

module flag_regfile (
  input  logic                      clk,
  input  logic                      rst,

  input  logic                      read_en,
  input  flag_types_pkg::reg_addr_t read_addr,
  input  logic                      retire_en,
  input  flag_types_pkg::reg_addr_t retire_addr,

  input  logic                      wr0_en,
  input  flag_types_pkg::reg_addr_t wr0_addr,
  input  flag_types_pkg::flag_t     wr0_data,
  input  logic                      wr1_en,
  input  flag_types_pkg::reg_addr_t wr1_addr,
  input  flag_types_pkg::flag_t     wr1_data,

  input  logic                      alloc_en,
  input  flag_types_pkg::reg_addr_t alloc_addr,

  output flag_types_pkg::entry_t    read_data,
  output flag_types_pkg::flag_t     retire_data,
  output logic                      init_busy
);

  localparam int WRITE_PORTS = flag_cfg_pkg::WRITE_PORTS;
  localparam int BANK_COUNT = flag_cfg_pkg::BANK_COUNT;
  localparam int ENTRY_COUNT = flag_cfg_pkg::ENTRY_COUNT;

  logic sweep_en;
  flag_types_pkg::reg_addr_t sweep_addr;

  // Per tile outputs, picked by the bypass
  flag_types_pkg::entry_t rd_entry [BANK_COUNT];
  flag_types_pkg::flag_t ret_flags [BANK_COUNT];

  flag_write_if #(.WRITE_PORTS(WRITE_PORTS)) wr_if ();

  flag_init_sweep #(
    .ENTRY_COUNT (ENTRY_COUNT)
  ) i_init_sweep (
    .clk        (clk),
    .rst        (rst),
    .sweep_en   (sweep_en),
    .sweep_addr (sweep_addr),
    .init_busy  (init_busy)
  );

  flag_write_stage #(
    .WRITE_PORTS (WRITE_PORTS)
  ) i_write_stage (
    .clk        (clk),
    .rst        (rst),
    .init_busy  (init_busy),
    .wr_en      ({wr1_en, wr0_en}),
    .wr_addr    ({wr1_addr, wr0_addr}),
    .wr_data    ({wr1_data, wr0_data}),
    .alloc_en   (alloc_en),
    .alloc_addr (alloc_addr),
    .sweep_en   (sweep_en),
    .sweep_addr (sweep_addr),
    .wr         (wr_if)
  );

  for (genvar b = 0; b < BANK_COUNT; b++)
  begin : g_bank
    flag_bank #(
      .BANK_INDEX  (b),
      .BANK_COUNT  (BANK_COUNT),
      .ENTRY_COUNT (ENTRY_COUNT),
      .WRITE_PORTS (WRITE_PORTS)
    ) i_bank (
      .clk         (clk),
      .rst         (rst),
      .read_en     (read_en),
      .read_addr   (read_addr),
      .retire_en   (retire_en),
      .retire_addr (retire_addr),
      .wr          (wr_if),
      .rd_entry    (rd_entry[b]),
      .ret_flags   (ret_flags[b])
    );
  end

  flag_read_bypass #(
    .BANK_COUNT  (BANK_COUNT),
    .WRITE_PORTS (WRITE_PORTS)
  ) i_read_bypass (
    .clk         (clk),
    .rst         (rst),
    .read_en     (read_en),
    .read_addr   (read_addr),
    .retire_en   (retire_en),
    .retire_addr (retire_addr),
    .rd_entry    (rd_entry),
    .ret_flags   (ret_flags),
    .wr          (wr_if),
    .read_data   (read_data),
    .retire_data (retire_data)
  );

endmodule

// File: src/flag_read_bypass.sv
// Tile select, staged write forwarding and result hold for read and retire
`timescale 1ns/1ps

module flag_read_bypass #(
  parameter int BANK_COUNT = flag_cfg_pkg::BANK_COUNT,
  parameter int WRITE_PORTS = flag_cfg_pkg::WRITE_PORTS
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      read_en,
  input  flag_types_pkg::reg_addr_t read_addr,
  input  logic                      retire_en,
  input  flag_types_pkg::reg_addr_t retire_addr,
  input  flag_types_pkg::entry_t    rd_entry [BANK_COUNT],
  input  flag_types_pkg::flag_t     ret_flags [BANK_COUNT],
  flag_write_if.bypass              wr,
  output flag_types_pkg::entry_t    read_data,
  output flag_types_pkg::flag_t     retire_data
);

  flag_types_pkg::reg_addr_t rd_addr_q;
  flag_types_pkg::bank_idx_t ret_bank_q;

  // Live flags mark the cycle right after an enabled read
  logic rd_live;
  logic ret_live;
  flag_types_pkg::entry_t rd_hold;
  flag_types_pkg::flag_t ret_hold;

  flag_types_pkg::entry_t rd_fwd;
  flag_types_pkg::flag_t ret_tile;

  always_comb
  begin
    rd_fwd = rd_entry[rd_addr_q[flag_cfg_pkg::BANK_BITS-1:0]];
    // Staged writes have not reached the tile yet
    for (int i = 0; i < WRITE_PORTS; i++)
    begin
      if (wr.wen[i] && wr.addr[i] == rd_addr_q)
        rd_fwd = {1'b0, wr.data[i]};
    end
    if (wr.alloc_en && wr.alloc_addr == rd_addr_q)
      rd_fwd = flag_types_pkg::ENTRY_ALLOC;
  end

  assign ret_tile = ret_flags[ret_bank_q];   // no forwarding on retire

  assign read_data = rd_live ? rd_fwd : rd_hold;
  assign retire_data = ret_live ? ret_tile : ret_hold;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rd_addr_q <= '0;
      ret_bank_q <= '0;
      rd_live <= 1'b0;
      ret_live <= 1'b0;
      rd_hold <= '0;
      ret_hold <= '0;
    end
    else
    begin
      rd_live <= read_en;
      ret_live <= retire_en;
      if (read_en)
        rd_addr_q <= read_addr;
      if (retire_en)
        ret_bank_q <= retire_addr[flag_cfg_pkg::BANK_BITS-1:0];
      if (rd_live)
        rd_hold <= rd_fwd;     // keep result while idle
      if (ret_live)
        ret_hold <= ret_tile;
    end
  end

endmodule

// File: bank/flag_bank.sv
// One storage tile of the flag register file with read and retire ports
`timescale 1ns/1ps

module flag_bank #(
  parameter int BANK_INDEX = 0,
  parameter int BANK_COUNT = flag_cfg_pkg::BANK_COUNT,
  parameter int ENTRY_COUNT = flag_cfg_pkg::ENTRY_COUNT,
  parameter int WRITE_PORTS = flag_cfg_pkg::WRITE_PORTS
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      read_en,
  input  flag_types_pkg::reg_addr_t read_addr,
  input  logic                      retire_en,
  input  flag_types_pkg::reg_addr_t retire_addr,
  flag_write_if.bank                wr,
  output flag_types_pkg::entry_t    rd_entry,
  output flag_types_pkg::flag_t     ret_flags
);

  localparam int ROW_COUNT = ENTRY_COUNT / BANK_COUNT;

  flag_types_pkg::entry_t mem [ROW_COUNT];
  flag_types_pkg::row_addr_t rd_row;
  flag_types_pkg::row_addr_t ret_row;

  function automatic logic in_bank(flag_types_pkg::reg_addr_t a);
    return a[flag_cfg_pkg::BANK_BITS-1:0] == flag_types_pkg::bank_idx_t'(BANK_INDEX);
  endfunction

  function automatic flag_types_pkg::row_addr_t row_of(flag_types_pkg::reg_addr_t a);
    return a[flag_cfg_pkg::ADDR_WIDTH-1:flag_cfg_pkg::BANK_BITS];
  endfunction

  // Later assignments win: port 0, port 1, allocate, sweep
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < WRITE_PORTS; i++)
    begin
      if (wr.wen[i] && in_bank(wr.addr[i]))
        mem[row_of(wr.addr[i])] <= {1'b0, wr.data[i]};   // pending cleared
    end
    if (wr.alloc_en && in_bank(wr.alloc_addr))
      mem[row_of(wr.alloc_addr)] <= flag_types_pkg::ENTRY_ALLOC;
    if (wr.sweep_en && in_bank(wr.sweep_addr))
      mem[row_of(wr.sweep_addr)] <= flag_types_pkg::ENTRY_CLEAR;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rd_row <= '0;
      ret_row <= '0;
    end
    else
    begin
      if (read_en && in_bank(read_addr))
        rd_row <= row_of(read_addr);
      if (retire_en && in_bank(retire_addr))
        ret_row <= row_of(retire_addr);
    end
  end

  // Array read after the address edge sees the write of the previous cycle
  assign rd_entry = mem[rd_row];
  assign ret_flags = mem[ret_row][flag_cfg_pkg::FLAG_WIDTH-1:0];

endmodule

// File: src/flag_write_stage.sv
// Write pipeline register for data writes, allocates and the init sweep
`timescale 1ns/1ps

module flag_write_stage #(
  parameter int WRITE_PORTS = flag_cfg_pkg::WRITE_PORTS
) (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic                                        init_busy,

  input  logic [WRITE_PORTS-1:0]                      wr_en,
  input  flag_types_pkg::reg_addr_t [WRITE_PORTS-1:0] wr_addr,
  input  flag_types_pkg::flag_t [WRITE_PORTS-1:0]     wr_data,

  input  logic                                        alloc_en,
  input  flag_types_pkg::reg_addr_t                   alloc_addr,

  input  logic                                        sweep_en,
  input  flag_types_pkg::reg_addr_t                   sweep_addr,

  flag_write_if.stage                                 wr
);

  // Requests during init are dropped, not delayed
  logic accept;

  assign accept = ~init_busy;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr.wen <= '0;
      wr.alloc_en <= 1'b0;
      wr.sweep_en <= 1'b0;
    end
    else
    begin
      wr.wen <= wr_en & {WRITE_PORTS{accept}};
      wr.alloc_en <= alloc_en & accept;
      wr.sweep_en <= sweep_en;
    end
  end

  // Payload follows the enables, no reset
  always_ff @(posedge clk)
  begin
    wr.addr <= wr_addr;
    wr.data <= wr_data;
    wr.alloc_addr <= alloc_addr;
    wr.sweep_addr <= sweep_addr;
  end

endmodule

// File: src/flag_init_sweep.sv
// Post-reset clear sweep over all entries with busy flag
`timescale 1ns/1ps

module flag_init_sweep #(
  parameter int ENTRY_COUNT = flag_cfg_pkg::ENTRY_COUNT
) (
  input  logic                      clk,
  input  logic                      rst,
  output logic                      sweep_en,
  output flag_types_pkg::reg_addr_t sweep_addr,
  output logic                      init_busy
);

  // Room for the entries plus the stage cycle and one more
  localparam int CNT_W = $clog2(ENTRY_COUNT + 3);

  logic [CNT_W-1:0] cnt;

  assign sweep_en = cnt < CNT_W'(ENTRY_COUNT);
  assign sweep_addr = cnt[flag_cfg_pkg::ADDR_WIDTH-1:0];

  // Busy until one cycle after the last staged clear is stored
  assign init_busy = cnt < CNT_W'(ENTRY_COUNT + 2);

  always_ff @(posedge clk)
  begin
    if (rst)
      cnt <= '0;
    else if (init_busy)
      cnt <= cnt + 1'b1;   // stops once busy drops
  end

endmodule

// File: common/flag_write_if.sv
// Staged write, allocate and sweep traffic between write stage, tiles and bypass
`timescale 1ns/1ps

interface flag_write_if #(
  parameter int WRITE_PORTS = flag_cfg_pkg::WRITE_PORTS
);

  // Data write ports, index 1 wins over index 0
  logic [WRITE_PORTS-1:0] wen;
  flag_types_pkg::reg_addr_t [WRITE_PORTS-1:0] addr;
  flag_types_pkg::flag_t [WRITE_PORTS-1:0] data;

  logic alloc_en;
  flag_types_pkg::reg_addr_t alloc_addr;

  // Init clear, highest priority
  logic sweep_en;
  flag_types_pkg::reg_addr_t sweep_addr;

  modport stage (
    output wen, addr, data,
    output alloc_en, alloc_addr,
    output sweep_en, sweep_addr
  );

  modport bank (
    input wen, addr, data,
    input alloc_en, alloc_addr,
    input sweep_en, sweep_addr
  );

  modport bypass (
    input wen, addr, data,
    input alloc_en, alloc_addr
  );

endinterface

// File: common/flag_types_pkg.sv
// Entry, flag, address and tile types of the condition flag register file
package flag_types_pkg;

  typedef logic [flag_cfg_pkg::FLAG_WIDTH-1:0] flag_t;

  // Pending bit sits above the flags
  typedef logic [flag_cfg_pkg::FLAG_WIDTH:0] entry_t;

  typedef logic [flag_cfg_pkg::ADDR_WIDTH-1:0] reg_addr_t;

  typedef logic [flag_cfg_pkg::BANK_BITS-1:0] bank_idx_t;

  // Row inside one tile, upper address bits
  typedef logic [flag_cfg_pkg::ADDR_WIDTH-flag_cfg_pkg::BANK_BITS-1:0] row_addr_t;

  // Allocated entry: pending set, flags all ones
  localparam entry_t ENTRY_ALLOC = '1;

  // Entry after the init sweep
  localparam entry_t ENTRY_CLEAR = '0;

endpackage

// File: common/flag_cfg_pkg.sv
// Size constants of the condition flag register file
package flag_cfg_pkg;

  // Flag value bits per entry, pending bit not included
  localparam int FLAG_WIDTH = 6;

  localparam int ENTRY_COUNT = 64;
  localparam int ADDR_WIDTH = 6;   // log2 of ENTRY_COUNT

  // Storage tiles, selected by the low address bits
  localparam int BANK_COUNT = 4;
  localparam int BANK_BITS = 2;

  // Data write ports; the allocate port comes on top of these
  localparam int WRITE_PORTS = 2;

endpackage
